// File: filelist.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/word_memory.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/cpu.sv
tb/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f filelist.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_cpu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1

// File: tb/tb_cpu.sv
`include "cpu_settings.svh"

module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pkg::*;

	// worst case adds up each test's load, 200 run cycles and 16 reads
	// which comes to about 1540 cycles for the six tests
	localparam int CYCLE_LIMIT = 2000;
	localparam int HLT_LIMIT   = 200;

	logic                       clk;
	logic                       reset;
	logic                       prog_we;
	logic [`IMEM_ADDR_BITS-1:0] prog_addr;
	logic [15:0]                prog_data;
	logic [3:0]                 dbg_sel;
	logic [15:0]                dbg_data;
	logic [15:0]                pc;
	logic                       hlt;

	// program image shared by the loader and the model
	logic [15:0] prog [0:(2**`IMEM_ADDR_BITS)-1];
	int          prog_len;

	// instruction-set model state
	logic [15:0] model_regs [0:15];
	logic [15:0] model_dmem [0:(2**`DMEM_ADDR_BITS)-1];
	logic [15:0] model_pc;
	logic        model_z;
	logic        model_v;
	logic        model_n;

	logic [31:0] lcg_state   = 32'h35d1_85b3;
	int          cycle_count = 0;
	int          error_count = 0;
	int          test_count  = 0;
	int          pass_count  = 0;

	cpu u_dut (
		.clk       (clk),
		.reset     (reset),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.dbg_sel   (dbg_sel),
		.dbg_data  (dbg_data),
		.pc        (pc),
		.hlt       (hlt)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// global watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped at the %0d cycle limit before the tests finished", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	// numerical recipes constants
	// the upper bits are the useful ones
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [15:0] reg_word(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] br_word(input logic [2:0] cond, input logic [8:0] off);
		return {OP_B, cond, off};
	endfunction

	function automatic logic [15:0] byte_word(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic emit(input logic [15:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// two instructions per 16-bit constant
	task automatic load_const(input logic [3:0] rd, input logic [15:0] value);
		emit(byte_word(OP_LLB, rd, value[7:0]));
		emit(byte_word(OP_LHB, rd, value[15:8]));
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0.1f ns: %s expected %h got %h", $realtime, name,
				expected, actual);
			error_count++;
		end
	endtask

	// walk the program image until hlt
	task automatic predict_state();
		logic [15:0]        w;
		logic [15:0]        a;
		logic [15:0]        b;
		logic [15:0]        res;
		logic [15:0]        addr;
		logic signed [16:0] wide;
		logic               write;
		logic               take;
		int                 steps;
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = '0;
		end
		model_pc = '0;
		model_z  = 1'b0;
		model_v  = 1'b0;
		model_n  = 1'b0;
		steps    = 0;
		w        = prog[model_pc[`IMEM_ADDR_BITS:1]];
		while (w[15:12] != OP_HLT && steps < HLT_LIMIT) begin
			a     = model_regs[w[7:4]];
			b     = model_regs[w[3:0]];
			// byte address from a word offset
			addr  = a + {{11{w[3]}}, w[3:0], 1'b0};
			res   = '0;
			write = 1'b0;
			take  = 1'b0;
			case (w[15:12])
				OP_ADD, OP_SUB: begin
					// one extra sign bit shows signed overflow
					if (w[15:12] == OP_ADD) begin
						wide = {a[15], a} + {b[15], b};
					end else begin
						wide = {a[15], a} - {b[15], b};
					end
					res     = wide[15:0];
					write   = 1'b1;
					model_z = (res == 16'h0000);
					model_n = res[15];
					model_v = (wide[16] != wide[15]);
				end
				OP_XOR, OP_AND, OP_SLL, OP_SRA, OP_ROR: begin
					case (w[15:12])
						OP_XOR:  res = a ^ b;
						OP_AND:  res = a & b;
						OP_SLL:  res = a << w[3:0];
						OP_SRA:  res = $signed(a) >>> w[3:0];
						default: res = (a >> w[3:0]) | (a << (5'd16 - {1'b0, w[3:0]}));
					endcase
					write   = 1'b1;
					model_z = (res == 16'h0000);
				end
				OP_LW: begin
					res   = model_dmem[addr[`DMEM_ADDR_BITS:1]];
					write = 1'b1;
				end
				OP_SW: begin
					model_dmem[addr[`DMEM_ADDR_BITS:1]] = model_regs[w[11:8]];
				end
				OP_LLB: begin
					res   = {model_regs[w[11:8]][15:8], w[7:0]};
					write = 1'b1;
				end
				OP_LHB: begin
					res   = {w[7:0], model_regs[w[11:8]][7:0]};
					write = 1'b1;
				end
				OP_B: begin
					case (w[11:9])
						COND_NE: take = !model_z;
						COND_EQ: take = model_z;
						COND_GT: take = !model_z && !model_n;
						COND_LT: take = model_n;
						COND_GE: take = model_z || !model_n;
						COND_LE: take = model_z || model_n;
						COND_OV: take = model_v;
						default: take = 1'b1;
					endcase
				end
				OP_PCS: begin
					res   = model_pc + 16'd2;
					write = 1'b1;
				end
				default: begin
				end
			endcase
			if (write) begin
				model_regs[w[11:8]] = res;
			end
			if (take) begin
				model_pc = model_pc + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0};
			end else begin
				model_pc = model_pc + 16'd2;
			end
			steps++;
			w = prog[model_pc[`IMEM_ADDR_BITS:1]];
		end
		if (w[15:12] != OP_HLT) begin
			$display("model did not reach hlt within %0d instructions", HLT_LIMIT);
			error_count++;
		end
	endtask

	// load under reset, run to hlt, compare pc and every register
	task automatic run_program(input string name);
		int reset_cycles;
		int wait_cycles;
		reset_cycles = (prog_len > 16) ? prog_len : 16;
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < reset_cycles; i++) begin
			prog_we   = (i < prog_len);
			prog_addr = i[`IMEM_ADDR_BITS-1:0];
			prog_data = prog[i];
			@(negedge clk);
		end
		prog_we     = 1'b0;
		reset       = 1'b0;
		wait_cycles = 0;
		while (!hlt && wait_cycles < HLT_LIMIT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!hlt) begin
			$display("%s: hlt did not rise within %0d cycles", name, HLT_LIMIT);
			error_count++;
		end
		predict_state();
		check_value("pc", model_pc, pc);
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			dbg_sel = i[3:0];
			#2;
			check_value($sformatf("r%0d", i), model_regs[i], dbg_data);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d failed checks", name, error_count - errors_before);
		end
	endtask

	// sub/add on r1=5, r2=5, r3=7fff, r4=1 into scratch r15
	task automatic set_flags(input int kind);
		case (kind)
			0: emit(reg_word(OP_SUB, 4'd15, 4'd1, 4'd2));
			1: emit(reg_word(OP_SUB, 4'd15, 4'd4, 4'd1));
			2: emit(reg_word(OP_SUB, 4'd15, 4'd1, 4'd4));
			default: emit(reg_word(OP_ADD, 4'd15, 4'd3, 4'd4));
		endcase
	endtask

	task automatic reset_state();
		int errors_before;
		errors_before = error_count;
		prog_len      = 0;
		emit(reg_word(OP_HLT, 4'd0, 4'd0, 4'd0));
		run_program("reset_state");
		check_value("pc", 16'h0000, pc);
		check_value("hlt", 16'h0001, {15'd0, hlt});
		finish_test("reset_state", errors_before);
	endtask

	task automatic alu_ops();
		int errors_before;
		errors_before = error_count;
		prog_len      = 0;
		load_const(4'd1, 16'h8421);
		load_const(4'd2, 16'h00f3);
		load_const(4'd3, 16'h7fff);
		load_const(4'd4, 16'h0001);
		emit(reg_word(OP_ADD, 4'd5, 4'd1, 4'd2));
		emit(reg_word(OP_SUB, 4'd6, 4'd2, 4'd1));
		emit(reg_word(OP_XOR, 4'd7, 4'd1, 4'd2));
		emit(reg_word(OP_AND, 4'd8, 4'd1, 4'd3));
		emit(reg_word(OP_SLL, 4'd9, 4'd1, 4'd3));
		emit(reg_word(OP_SRA, 4'd10, 4'd1, 4'd5));
		emit(reg_word(OP_ROR, 4'd11, 4'd1, 4'd7));
		// 7fff + 1 wraps
		emit(reg_word(OP_ADD, 4'd12, 4'd3, 4'd4));
		emit(reg_word(OP_ROR, 4'd13, 4'd2, 4'd0));
		emit(reg_word(OP_SRA, 4'd14, 4'd1, 4'd15));
		emit(reg_word(OP_SUB, 4'd15, 4'd4, 4'd4));
		emit(reg_word(OP_HLT, 4'd0, 4'd0, 4'd0));
		run_program("alu_ops");
		finish_test("alu_ops", errors_before);
	endtask

	task automatic load_store();
		int          errors_before;
		logic [31:0] r;
		// 0, +3, -2, +7, -8 words from the base
		logic [3:0]  offs [5] = '{4'h0, 4'h3, 4'he, 4'h7, 4'h8};
		errors_before = error_count;
		prog_len      = 0;
		load_const(4'd1, 16'h0040);
		for (int i = 0; i < 5; i++) begin
			r = next_rand();
			load_const(4'(i + 2), r[31:16]);
		end
		for (int i = 0; i < 5; i++) begin
			emit(reg_word(OP_SW, 4'(i + 2), 4'd1, offs[i]));
		end
		// read back into r7..r11
		for (int i = 0; i < 5; i++) begin
			emit(reg_word(OP_LW, 4'(i + 7), 4'd1, offs[i]));
		end
		emit(reg_word(OP_HLT, 4'd0, 4'd0, 4'd0));
		run_program("load_store");
		finish_test("load_store", errors_before);
	endtask

	task automatic branch_conditions();
		int         errors_before;
		logic [3:0] marker;
		// flag setup per condition so that most conditions see taken and not taken
		int         fwd_setup [8] = '{0, 0, 2, 1, 0, 2, 3, 3};
		int         bwd_setup [8] = '{2, 1, 1, 0, 1, 1, 2, 0};
		errors_before = error_count;
		prog_len      = 0;
		load_const(4'd1, 16'h0005);
		load_const(4'd2, 16'h0005);
		load_const(4'd3, 16'h7fff);
		load_const(4'd4, 16'h0001);
		for (int c = 0; c < 8; c++) begin
			marker = 4'(c + 6);
			// forward branch skips the low byte marker when taken
			set_flags(fwd_setup[c]);
			emit(br_word(3'(c), 9'd1));
			emit(byte_word(OP_LLB, marker, 8'(16 + c)));
			// backward case hops over the marker and then branches back to it
			set_flags(bwd_setup[c]);
			emit(br_word(COND_AL, 9'd2));
			emit(byte_word(OP_LHB, marker, 8'(32 + c)));
			emit(br_word(COND_AL, 9'd1));
			emit(br_word(3'(c), 9'h1fd));
		end
		emit(reg_word(OP_HLT, 4'd0, 4'd0, 4'd0));
		run_program("branch_conditions");
		finish_test("branch_conditions", errors_before);
	endtask

	task automatic link_and_halt();
		int          errors_before;
		logic [15:0] hlt_addr;
		errors_before = error_count;
		prog_len      = 0;
		emit(reg_word(OP_NOP7, 4'd0, 4'd0, 4'd0));
		emit(reg_word(OP_NOP13, 4'd9, 4'd9, 4'd9));
		emit(reg_word(OP_PCS, 4'd1, 4'd0, 4'd0));
		emit(byte_word(OP_LLB, 4'd2, 8'h55));
		emit(reg_word(OP_PCS, 4'd3, 4'd0, 4'd0));
		emit(br_word(COND_AL, 9'd1));
		// skipped by the branch above
		emit(reg_word(OP_PCS, 4'd4, 4'd0, 4'd0));
		emit(reg_word(OP_PCS, 4'd5, 4'd0, 4'd0));
		emit(reg_word(OP_HLT, 4'd0, 4'd0, 4'd0));
		hlt_addr = 16'(2 * (prog_len - 1));
		run_program("link_and_halt");
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_value("pc while halted", hlt_addr, pc);
			check_value("hlt while halted", 16'h0001, {15'd0, hlt});
		end
		finish_test("link_and_halt", errors_before);
	endtask

	task automatic random_alu();
		int          errors_before;
		logic [31:0] r;
		errors_before = error_count;
		prog_len      = 0;
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			load_const(4'(i), r[31:16]);
		end
		// add, sub, xor and and on random registers
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			emit(reg_word({2'b00, r[29:28]}, r[27:24], r[23:20], r[19:16]));
		end
		emit(reg_word(OP_HLT, 4'd0, 4'd0, 4'd0));
		run_program("random_alu");
		finish_test("random_alu", errors_before);
	endtask

	initial begin
		reset     = 1'b1;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_sel   = '0;
		reset_state();
		alu_ops();
		load_store();
		branch_conditions();
		link_and_halt();
		random_alu();
		$display("%0d of %0d tests ok, %0d failed checks", pass_count, test_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: hdl/cpu.sv
`include "cpu_settings.svh"

module cpu (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       prog_we,
	input  logic [`IMEM_ADDR_BITS-1:0] prog_addr,
	input  logic [15:0]                prog_data,
	input  logic [3:0]                 dbg_sel,
	output logic [15:0]                dbg_data,
	output logic [15:0]                pc,
	output logic                       hlt
);
	import cpu_pkg::*;

	// fetched instruction
	instr_t instr;

	// decoder controls
	logic       reg_write;
	logic       mem_write;
	logic       alu_src_imm;
	logic       src2_is_rd;
	logic [1:0] wb_sel;

	// datapath
	logic [15:0] rdata1;
	logic [15:0] rdata2;
	logic [15:0] result;
	logic [15:0] mem_data;
	logic [15:0] pc_plus2;
	logic [2:0]  flag_new;
	logic [2:0]  flag_wen;

	// instruction memory, written only through the program port
	word_memory #(.addr_bits(`IMEM_ADDR_BITS)) u_imem (
		.clk   (clk),
		.we    (prog_we),
		.waddr (prog_addr),
		.wdata (prog_data),
		.raddr (pc[`IMEM_ADDR_BITS:1]),
		.rdata (instr)
	);

	decode_unit u_decode (
		.opcode      (instr.r.opcode),
		.reg_write   (reg_write),
		.mem_write   (mem_write),
		.alu_src_imm (alu_src_imm),
		.src2_is_rd  (src2_is_rd),
		.wb_sel      (wb_sel),
		.halt        (hlt)
	);

	// destination is always bits 11:8
	register_file u_regs (
		.clk        (clk),
		.reset      (reset),
		.rs         (instr.r.rs),
		.rt         (instr.r.rt),
		.rd         (instr.r.rd),
		.src2_is_rd (src2_is_rd),
		.reg_write  (reg_write),
		.wb_sel     (wb_sel),
		.alu_result (result),
		.mem_data   (mem_data),
		.link_pc    (pc_plus2),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.dbg_sel    (dbg_sel),
		.dbg_data   (dbg_data)
	);

	alu u_alu (
		.instr       (instr),
		.a           (rdata1),
		.b           (rdata2),
		.alu_src_imm (alu_src_imm),
		.result      (result),
		.flag_new    (flag_new),
		.flag_wen    (flag_wen)
	);

	// byte address from the ALU, word-indexed array
	word_memory #(.addr_bits(`DMEM_ADDR_BITS)) u_dmem (
		.clk   (clk),
		.we    (mem_write),
		.waddr (result[`DMEM_ADDR_BITS:1]),
		.wdata (rdata2),
		.raddr (result[`DMEM_ADDR_BITS:1]),
		.rdata (mem_data)
	);

	branch_unit u_branch (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.halt     (hlt),
		.flag_new (flag_new),
		.flag_wen (flag_wen),
		.pc       (pc),
		.pc_plus2 (pc_plus2)
	);

endmodule

// File: hdl/branch_unit.sv
module branch_unit (
	input  logic            clk,
	input  logic            reset,
	input  cpu_pkg::instr_t instr,
	input  logic            halt,
	input  logic [2:0]      flag_new,
	input  logic [2:0]      flag_wen,
	output logic [15:0]     pc,
	output logic [15:0]     pc_plus2
);
	import cpu_pkg::*;

	logic [2:0]  flags;
	logic [15:0] target;
	logic [15:0] pc_next;
	logic        cond_true;

	assign pc_plus2 = pc + 16'd2;
	// imm9 counts words from the following instruction
	assign target   = pc_plus2 + {{6{instr.b.imm9[8]}}, instr.b.imm9, 1'b0};

	// condition test against flags from earlier instructions
	always_comb begin
		case (instr.b.cond)
			COND_NE: cond_true = !flags[FLAG_Z];
			COND_EQ: cond_true = flags[FLAG_Z];
			COND_GT: cond_true = !flags[FLAG_Z] && !flags[FLAG_N];
			COND_LT: cond_true = flags[FLAG_N];
			COND_GE: cond_true = flags[FLAG_Z] || !flags[FLAG_N];
			COND_LE: cond_true = flags[FLAG_Z] || flags[FLAG_N];
			COND_OV: cond_true = flags[FLAG_V];
			COND_AL: cond_true = 1'b1;
			default: cond_true = 1'b0;
		endcase
	end

	assign pc_next = ((instr.b.opcode == OP_B) && cond_true) ? target : pc_plus2;

	// hlt freezes pc and flags
	always_ff @(posedge clk) begin
		if (reset) begin
			pc    <= '0;
			flags <= '0;
		end else if (!halt) begin
			pc <= pc_next;
			for (int i = 0; i < 3; i++) begin
				if (flag_wen[i]) begin
					flags[i] <= flag_new[i];
				end
			end
		end
	end

endmodule

// File: hdl/alu.sv
module alu (
	input  cpu_pkg::instr_t instr,
	input  logic [15:0]     a,
	input  logic [15:0]     b,
	input  logic            alu_src_imm,
	output logic [15:0]     result,
	output logic [2:0]      flag_new,
	output logic [2:0]      flag_wen
);
	import cpu_pkg::*;

	logic [15:0]        imm_ext;
	logic [15:0]        operand;
	logic [3:0]         shamt;
	logic [15:0]        sum;
	logic [15:0]        diff;
	logic [15:0]        addr;
	logic [31:0]        rot;
	logic signed [15:0] a_signed;
	logic               add_ovf;
	logic               sub_ovf;

	// low nibble is the immediate for shifts and memory offsets
	assign imm_ext  = {{12{instr.r.rt[3]}}, instr.r.rt};
	assign operand  = alu_src_imm ? imm_ext : b;
	assign shamt    = operand[3:0];
	assign sum      = a + operand;
	assign diff     = a - operand;
	// offsets count words, so scale by two
	assign addr     = a + {operand[14:0], 1'b0};
	// rotate by taking a window out of the doubled word
	assign rot      = {a, a} >> shamt;
	assign a_signed = a;

	// signed overflow from operand and result signs
	assign add_ovf = (a[15] == operand[15]) && (sum[15] != a[15]);
	assign sub_ovf = (a[15] != operand[15]) && (diff[15] != a[15]);

	always_comb begin
		result   = sum;
		flag_wen = '0;
		flag_new = '0;
		case (instr.r.opcode)
			OP_ADD: begin
				result           = sum;
				flag_wen         = '1;
				flag_new[FLAG_V] = add_ovf;
			end
			OP_SUB: begin
				result           = diff;
				flag_wen         = '1;
				flag_new[FLAG_V] = sub_ovf;
			end
			// logic ops and shifts only touch Z
			OP_XOR: begin
				result           = a ^ operand;
				flag_wen[FLAG_Z] = 1'b1;
			end
			OP_AND: begin
				result           = a & operand;
				flag_wen[FLAG_Z] = 1'b1;
			end
			OP_SLL: begin
				result           = a << shamt;
				flag_wen[FLAG_Z] = 1'b1;
			end
			OP_SRA: begin
				result           = a_signed >>> shamt;
				flag_wen[FLAG_Z] = 1'b1;
			end
			OP_ROR: begin
				result           = rot[15:0];
				flag_wen[FLAG_Z] = 1'b1;
			end
			OP_LW, OP_SW: result = addr;
			// b carries the old rd on port 2
			OP_LLB: result = {b[15:8], instr.i.imm8};
			OP_LHB: result = {instr.i.imm8, b[7:0]};
			default: result = sum;
		endcase
		flag_new[FLAG_Z] = (result == 16'h0000);
		flag_new[FLAG_N] = result[15];
	end

endmodule

// File: hdl/register_file.sv
module register_file (
	input  logic        clk,
	input  logic        reset,
	input  logic [3:0]  rs,
	input  logic [3:0]  rt,
	input  logic [3:0]  rd,
	input  logic        src2_is_rd,
	input  logic        reg_write,
	input  logic [1:0]  wb_sel,
	input  logic [15:0] alu_result,
	input  logic [15:0] mem_data,
	input  logic [15:0] link_pc,
	output logic [15:0] rdata1,
	output logic [15:0] rdata2,
	input  logic [3:0]  dbg_sel,
	output logic [15:0] dbg_data
);
	import cpu_pkg::*;

	logic [15:0] regs [0:15];
	logic [15:0] wdata;

	// writeback source
	always_comb begin
		case (wb_sel)
			WB_MEM:  wdata = mem_data;
			WB_LINK: wdata = link_pc;
			default: wdata = alu_result;
		endcase
	end

	// port 2 swaps to rd for sw and the byte loads
	assign rdata1   = regs[rs];
	assign rdata2   = src2_is_rd ? regs[rd] : regs[rt];
	assign dbg_data = regs[dbg_sel];

	// r0 is an ordinary register here
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[rd] <= wdata;
		end
	end

endmodule

// File: hdl/decode_unit.sv
module decode_unit (
	input  logic [3:0] opcode,
	output logic       reg_write,
	output logic       mem_write,
	output logic       alu_src_imm,
	output logic       src2_is_rd,
	output logic [1:0] wb_sel,
	output logic       halt
);
	import cpu_pkg::*;

	always_comb begin
		// defaults describe a no-op
		reg_write   = 1'b0;
		mem_write   = 1'b0;
		alu_src_imm = 1'b0;
		src2_is_rd  = 1'b0;
		wb_sel      = WB_ALU;
		halt        = 1'b0;
		case (opcode)
			OP_ADD, OP_SUB, OP_XOR, OP_AND: begin
				reg_write = 1'b1;
			end
			// shift amount comes from the instruction, not a register
			OP_SLL, OP_SRA, OP_ROR: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
			end
			OP_LW: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				wb_sel      = WB_MEM;
			end
			// store data is the register in the rd slot
			OP_SW: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
				src2_is_rd  = 1'b1;
			end
			// old rd value is needed for the byte merge
			OP_LLB, OP_LHB: begin
				reg_write  = 1'b1;
				src2_is_rd = 1'b1;
			end
			OP_PCS: begin
				reg_write = 1'b1;
				wb_sel    = WB_LINK;
			end
			OP_HLT: begin
				halt = 1'b1;
			end
			// branch only touches pc, handled in the branch unit
			OP_B, OP_NOP7, OP_NOP13: begin
				reg_write = 1'b0;
			end
			default: begin
				reg_write = 1'b0;
			end
		endcase
	end

endmodule

// File: hdl/word_memory.sv
module word_memory #(
	parameter int addr_bits = 8
) (
	input  logic                 clk,
	input  logic                 we,
	input  logic [addr_bits-1:0] waddr,
	input  logic [15:0]          wdata,
	input  logic [addr_bits-1:0] raddr,
	output logic [15:0]          rdata
);

	// plain word array, contents survive reset
	logic [15:0] mem [0:(2**addr_bits)-1];

	// read path is asynchronous so fetch and load finish in the same cycle
	assign rdata = mem[raddr];

	// write lands on the rising edge
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

	// register format: rd, rs, rt (rt doubles as the 4-bit immediate)
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} reg_fmt_t;

	// branch format: condition and signed word offset
	typedef struct packed {
		logic [3:0] opcode;
		logic [2:0] cond;
		logic [8:0] imm9;
	} br_fmt_t;

	// byte format for llb and lhb
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [7:0] imm8;
	} byte_fmt_t;

	// one instruction word seen three ways
	typedef union packed {
		reg_fmt_t  r;
		br_fmt_t   b;
		byte_fmt_t i;
	} instr_t;

	localparam logic [3:0] OP_ADD   = 4'd0;
	localparam logic [3:0] OP_SUB   = 4'd1;
	localparam logic [3:0] OP_XOR   = 4'd2;
	localparam logic [3:0] OP_AND   = 4'd3;
	localparam logic [3:0] OP_SLL   = 4'd4;
	localparam logic [3:0] OP_SRA   = 4'd5;
	localparam logic [3:0] OP_ROR   = 4'd6;
	localparam logic [3:0] OP_NOP7  = 4'd7;
	localparam logic [3:0] OP_LW    = 4'd8;
	localparam logic [3:0] OP_SW    = 4'd9;
	localparam logic [3:0] OP_LLB   = 4'd10;
	localparam logic [3:0] OP_LHB   = 4'd11;
	localparam logic [3:0] OP_B     = 4'd12;
	localparam logic [3:0] OP_NOP13 = 4'd13;
	localparam logic [3:0] OP_PCS   = 4'd14;
	localparam logic [3:0] OP_HLT   = 4'd15;

	localparam logic [2:0] COND_NE = 3'd0;
	localparam logic [2:0] COND_EQ = 3'd1;
	localparam logic [2:0] COND_GT = 3'd2;
	localparam logic [2:0] COND_LT = 3'd3;
	localparam logic [2:0] COND_GE = 3'd4;
	localparam logic [2:0] COND_LE = 3'd5;
	localparam logic [2:0] COND_OV = 3'd6;
	localparam logic [2:0] COND_AL = 3'd7;

	// bit positions inside the 3-bit flag word
	localparam int FLAG_N = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_Z = 2;

	// register write source
	localparam logic [1:0] WB_ALU  = 2'd0;
	localparam logic [1:0] WB_MEM  = 2'd1;
	localparam logic [1:0] WB_LINK = 2'd2;

endpackage

// File: hdl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// word-address width of the instruction memory, 256 words
`define IMEM_ADDR_BITS 8

// word-address width of the data memory, 256 words
`define DMEM_ADDR_BITS 8

`endif
